//--- logic/dma_pkg.sv
// Shared constants and types for the four-channel DMA engine.
// Register map is fixed: 4 channels x 4 registers, 16 bytes per channel.
// Addresses and counts are 24-bit byte values; the memory port is word-aligned.
`default_nettype none

package dma_pkg;

    localparam int NUM_CHAN      = 4;
    localparam int CHAN_W        = 2;
    localparam int ADDR_W        = 24;
    localparam int DATA_W        = 32;
    localparam int NUM_REQ       = 16;
    localparam int REQ_IDX_W     = $clog2(NUM_REQ);
    localparam int REG_ADDR_W    = 6;
    localparam int CTRL_W        = 13;
    localparam int REGS_PER_CHAN = 4;
    // Byte offset width inside one channel block
    localparam int BLK_W         = $clog2(REGS_PER_CHAN) + 2;

    localparam logic [BLK_W-1:0] REG_SRC  = 'h0;
    localparam logic [BLK_W-1:0] REG_DST  = 'h4;
    localparam logic [BLK_W-1:0] REG_CTRL = 'h8;
    localparam logic [BLK_W-1:0] REG_CNT  = 'hc;

    localparam int CTRL_SRC_REQ_LSB = 0;
    localparam int CTRL_DST_REQ_LSB = 4;
    localparam int CTRL_SRC_INC     = 8;
    localparam int CTRL_DST_INC     = 9;
    localparam int CTRL_SIZE_LSB    = 10;
    localparam int CTRL_NULL_TERM   = 12;
    localparam int CTRL_DONE_BIT    = 31;

    // Encoding 3 is treated as 32-bit
    typedef enum logic [1:0] {
        SIZE_8  = 2'd0,
        SIZE_16 = 2'd1,
        SIZE_32 = 2'd2
    } xfer_size_e;

    typedef enum logic [1:0] {
        ST_READ   = 2'd0,
        ST_WRITE  = 2'd1,
        ST_UPDATE = 2'd2
    } eng_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [CTRL_W-1:0] ctrl;
        logic [ADDR_W-1:0] cnt;
    } chan_regs_t;

    typedef struct packed {
        logic              wr;
        logic [CHAN_W-1:0] seq;
        logic [3:0]        mask;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              rdone;
        logic              wdone;
        logic [CHAN_W-1:0] seq;
        logic [3:0]        mask;
        logic [DATA_W-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic [NUM_CHAN-1:0] sel;
        logic                update;
        logic                null_trans;
        logic [ADDR_W-1:0]   next_src;
        logic [ADDR_W-1:0]   next_dst;
        logic [ADDR_W-1:0]   next_cnt;
    } chan_upd_t;

    // One data word seen as byte lanes or half-word lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } lane_word_u;

endpackage

`default_nettype wire

//--- logic/dma_regs.sv
// Channel register file: src, dst, ctrl and cnt per channel.
// Software writes take priority over engine updates in the same cycle.
// Read-back is combinational; ctrl bit 31 returns the registered done flag.
`timescale 1ns/1ps
`default_nettype none

module dma_regs import dma_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         reg_wr,
    input  wire logic [REG_ADDR_W-1:0]        reg_addr,
    input  wire logic [DATA_W-1:0]            reg_wdata,
    output logic      [DATA_W-1:0]            reg_rdata,
    input  wire chan_upd_t                    upd,
    input  wire logic [NUM_CHAN-1:0]          read_pending,
    input  wire logic [NUM_CHAN-1:0]          write_pending,
    output chan_regs_t [NUM_CHAN-1:0]         chan_regs,
    output logic      [NUM_CHAN-1:0]          done
);

    logic [CHAN_W-1:0]   reg_chan;
    logic [BLK_W-1:0]    reg_off;
    logic [NUM_CHAN-1:0] chan_hit;
    chan_regs_t          rd;

    // Upper offset bits pick the channel block
    assign reg_chan = reg_addr[REG_ADDR_W-1 -: CHAN_W];
    assign reg_off  = reg_addr[BLK_W-1:0];
    assign chan_hit = reg_wr ? (NUM_CHAN'(1) << reg_chan) : '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            chan_regs <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                if (chan_hit[i] && (reg_off == REG_SRC))
                    chan_regs[i].src <= reg_wdata[ADDR_W-1:0];
                else if (upd.sel[i] && upd.update && chan_regs[i].ctrl[CTRL_SRC_INC])
                    chan_regs[i].src <= upd.next_src;

                if (chan_hit[i] && (reg_off == REG_DST))
                    chan_regs[i].dst <= reg_wdata[ADDR_W-1:0];
                else if (upd.sel[i] && upd.update && chan_regs[i].ctrl[CTRL_DST_INC])
                    chan_regs[i].dst <= upd.next_dst;

                if (chan_hit[i] && (reg_off == REG_CTRL))
                    chan_regs[i].ctrl <= reg_wdata[CTRL_W-1:0];

                // Writing a non-zero count starts the channel
                if (chan_hit[i] && (reg_off == REG_CNT))
                    chan_regs[i].cnt <= reg_wdata[ADDR_W-1:0];
                else if (upd.sel[i] && upd.null_trans && chan_regs[i].ctrl[CTRL_NULL_TERM])
                    chan_regs[i].cnt <= '0;
                else if (upd.sel[i] && upd.update)
                    chan_regs[i].cnt <= upd.next_cnt;
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            done <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_CHAN; i++)
                done[i] <= !read_pending[i] && !write_pending[i] && (chan_regs[i].cnt == '0);
        end
    end

    always_comb
    begin
        rd        = chan_regs[reg_chan];
        reg_rdata = '0;
        case (reg_off)
            REG_SRC: reg_rdata[ADDR_W-1:0] = rd.src;
            REG_DST: reg_rdata[ADDR_W-1:0] = rd.dst;
            REG_CTRL:
            begin
                reg_rdata[CTRL_W-1:0]    = rd.ctrl;
                reg_rdata[CTRL_DONE_BIT] = done[reg_chan];
            end
            REG_CNT: reg_rdata[ADDR_W-1:0] = rd.cnt;
            default: reg_rdata = '0;
        endcase
    end

    // Engine updates at most one channel per cycle
    a_upd_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(upd.sel));

endmodule

`default_nettype wire

//--- logic/dma_rsp_track.sv
// Per-channel read/write pending flags and captured read data.
// Allows one read and one write in flight per channel.
// Read data is replicated across all lanes according to the response mask.
`timescale 1ns/1ps
`default_nettype none

module dma_rsp_track import dma_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire mem_req_t                        mem_req,
    input  wire logic                            mem_req_valid,
    input  wire logic                            mem_busy,
    input  wire mem_rsp_t                        mem_rsp,
    output logic [NUM_CHAN-1:0]                  read_pending,
    output logic [NUM_CHAN-1:0]                  write_pending,
    output logic [NUM_CHAN-1:0][DATA_W-1:0]      chan_rdata
);

    logic                accept;
    logic [NUM_CHAN-1:0] req_chan;
    logic [NUM_CHAN-1:0] rsp_chan;
    lane_word_u          rsp_word;
    lane_word_u          rep_word;

    assign accept   = mem_req_valid && !mem_busy;
    assign req_chan = NUM_CHAN'(1) << mem_req.seq;
    assign rsp_chan = NUM_CHAN'(1) << mem_rsp.seq;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            read_pending  <= '0;
            write_pending <= '0;
        end
        else
        begin
            read_pending  <= (read_pending | ((accept && !mem_req.wr) ? req_chan : '0))
                             & ~(mem_rsp.rdone ? rsp_chan : '0);
            write_pending <= (write_pending | ((accept && mem_req.wr) ? req_chan : '0))
                             & ~(mem_rsp.wdone ? rsp_chan : '0);
        end
    end

    // Full word, a half, or a single byte lane
    always_comb
    begin
        rsp_word = mem_rsp.data;
        rep_word = rsp_word;
        if (mem_rsp.mask == 4'b1111)
            rep_word = rsp_word;
        else if (mem_rsp.mask[3:2] == 2'b11)
            rep_word.halves = {2{rsp_word.halves[1]}};
        else if (mem_rsp.mask[1:0] == 2'b11)
            rep_word.halves = {2{rsp_word.halves[0]}};
        else if (mem_rsp.mask[3])
            rep_word.bytes = {4{rsp_word.bytes[3]}};
        else if (mem_rsp.mask[2])
            rep_word.bytes = {4{rsp_word.bytes[2]}};
        else if (mem_rsp.mask[1])
            rep_word.bytes = {4{rsp_word.bytes[1]}};
        else
            rep_word.bytes = {4{rsp_word.bytes[0]}};
    end

    always_ff @(posedge clk)
    begin
        if (mem_rsp.rdone)
            chan_rdata[mem_rsp.seq] <= rep_word;
    end

    a_rdone_pending: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.rdone |-> read_pending[mem_rsp.seq]);
    a_wdone_pending: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.wdone |-> write_pending[mem_rsp.seq]);

endmodule

`default_nettype wire

//--- logic/dma_engine.sv
// Transfer engine serving one channel per cycle, chosen the cycle before.
// Each unit is read request, write request, then a one-cycle status update.
// Request lines are registered once; a held request may be withdrawn
// when another channel is chosen.
`timescale 1ns/1ps
`default_nettype none

module dma_engine import dma_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [NUM_REQ-1:0]              req,
    input  wire chan_regs_t [NUM_CHAN-1:0]       chan_regs,
    input  wire logic [NUM_CHAN-1:0]             read_pending,
    input  wire logic [NUM_CHAN-1:0]             write_pending,
    input  wire logic [NUM_CHAN-1:0][DATA_W-1:0] chan_rdata,
    input  wire logic                            mem_busy,
    output mem_req_t                             mem_req,
    output logic                                 mem_req_valid,
    output chan_upd_t                            upd
);

    logic [NUM_REQ-1:0]          req_q;
    logic [CHAN_W-1:0]           chan_num;
    logic [CHAN_W-1:0]           chan_pick;
    eng_state_e [NUM_CHAN-1:0]   state_q;
    eng_state_e                  next_state;
    chan_regs_t                  cur;
    xfer_size_e                  size;
    logic                        src_req;
    logic                        dst_req;
    logic [3:0]                  src_mask;
    logic [3:0]                  dst_mask;
    logic [ADDR_W-1:0]           next_src;
    logic [ADDR_W-1:0]           next_dst;
    logic [ADDR_W-1:0]           next_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            req_q <= '0;
        else
            req_q <= req;
    end

    assign cur     = chan_regs[chan_num];
    assign size    = xfer_size_e'(cur.ctrl[CTRL_SIZE_LSB +: 2]);
    assign src_req = req_q[cur.ctrl[CTRL_SRC_REQ_LSB +: REQ_IDX_W]];
    assign dst_req = req_q[cur.ctrl[CTRL_DST_REQ_LSB +: REQ_IDX_W]];

    // Next values are rounded down to the transfer size
    always_comb
    begin
        case (size)
            SIZE_8:
            begin
                next_src = cur.src + ADDR_W'(1);
                next_dst = cur.dst + ADDR_W'(1);
                next_cnt = cur.cnt - ADDR_W'(1);
                src_mask = 4'b0001 << cur.src[1:0];
                dst_mask = 4'b0001 << cur.dst[1:0];
            end
            SIZE_16:
            begin
                next_src = (cur.src + ADDR_W'(2)) & ~ADDR_W'(1);
                next_dst = (cur.dst + ADDR_W'(2)) & ~ADDR_W'(1);
                next_cnt = (cur.cnt - ADDR_W'(2)) & ~ADDR_W'(1);
                src_mask = cur.src[1] ? 4'b1100 : 4'b0011;
                dst_mask = cur.dst[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                next_src = (cur.src + ADDR_W'(4)) & ~ADDR_W'(3);
                next_dst = (cur.dst + ADDR_W'(4)) & ~ADDR_W'(3);
                next_cnt = (cur.cnt - ADDR_W'(4)) & ~ADDR_W'(3);
                src_mask = 4'b1111;
                dst_mask = 4'b1111;
            end
        endcase
    end

    always_comb
    begin
        next_state    = state_q[chan_num];
        mem_req_valid = 1'b0;
        mem_req       = '0;
        mem_req.seq   = chan_num;
        upd           = '0;
        upd.sel       = NUM_CHAN'(1) << chan_num;
        upd.next_src  = next_src;
        upd.next_dst  = next_dst;
        upd.next_cnt  = next_cnt;

        if (cur.cnt == '0)
        begin
            next_state = ST_READ;
        end
        else
        begin
            case (state_q[chan_num])
                ST_READ:
                begin
                    if (src_req && !read_pending[chan_num])
                    begin
                        mem_req_valid = 1'b1;
                        mem_req.mask  = src_mask;
                        mem_req.addr  = {cur.src[ADDR_W-1:2], 2'b00};
                        if (!mem_busy)
                            next_state = ST_WRITE;
                    end
                end
                ST_WRITE:
                begin
                    // Needs the read data and a free write slot
                    if (dst_req && !read_pending[chan_num] && !write_pending[chan_num])
                    begin
                        mem_req_valid = 1'b1;
                        mem_req.wr    = 1'b1;
                        mem_req.mask  = dst_mask;
                        mem_req.addr  = {cur.dst[ADDR_W-1:2], 2'b00};
                        mem_req.wdata = chan_rdata[chan_num];
                        if (!mem_busy)
                            next_state = ST_UPDATE;
                    end
                end
                ST_UPDATE:
                begin
                    upd.update     = 1'b1;
                    upd.null_trans = (chan_rdata[chan_num] == '0);
                    next_state     = ST_READ;
                end
                default: next_state = ST_READ;
            endcase
        end
    end

    // Lowest idle channel with work, else the last one
    always_comb
    begin
        chan_pick = CHAN_W'(NUM_CHAN - 1);
        for (int i = NUM_CHAN - 1; i >= 0; i--)
        begin
            if (!read_pending[i] && (chan_regs[i].cnt != '0))
                chan_pick = CHAN_W'(i);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            chan_num <= '0;
            state_q  <= {NUM_CHAN{ST_READ}};
        end
        else
        begin
            chan_num          <= chan_pick;
            state_q[chan_num] <= next_state;
        end
    end

    // A refused request stays offered unless dropped or replaced by another channel
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && mem_busy) |=> !mem_req_valid
            || (mem_req.seq != $past(mem_req.seq)) || (mem_req == $past(mem_req)));

endmodule

`default_nettype wire

//--- logic/dma_top.sv
// Four-channel DMA top level.
// Register port: write strobe, combinational read-back.
// Memory port: mem_busy is back-pressure, responses are strobes tagged by channel.
`timescale 1ns/1ps
`default_nettype none

module dma_top import dma_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     reg_wr,
    input  wire logic [REG_ADDR_W-1:0]    reg_addr,
    input  wire logic [DATA_W-1:0]        reg_wdata,
    output logic      [DATA_W-1:0]        reg_rdata,
    output mem_req_t                      mem_req,
    output logic                          mem_req_valid,
    input  wire logic                     mem_busy,
    input  wire mem_rsp_t                 mem_rsp,
    input  wire logic [NUM_REQ-1:0]       req,
    output logic      [NUM_CHAN-1:0]      done
);

    chan_regs_t [NUM_CHAN-1:0]       chan_regs;
    chan_upd_t                       upd;
    logic [NUM_CHAN-1:0]             read_pending;
    logic [NUM_CHAN-1:0]             write_pending;
    logic [NUM_CHAN-1:0][DATA_W-1:0] chan_rdata;

    dma_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .upd           (upd),
        .read_pending  (read_pending),
        .write_pending (write_pending),
        .chan_regs     (chan_regs),
        .done          (done)
    );

    dma_rsp_track u_rsp_track (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_busy      (mem_busy),
        .mem_rsp       (mem_rsp),
        .read_pending  (read_pending),
        .write_pending (write_pending),
        .chan_rdata    (chan_rdata)
    );

    dma_engine u_engine (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .chan_regs     (chan_regs),
        .read_pending  (read_pending),
        .write_pending (write_pending),
        .chan_rdata    (chan_rdata),
        .mem_busy      (mem_busy),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .upd           (upd)
    );

endmodule

`default_nettype wire

//--- test/mem_model.sv
// Memory responder for the DMA testbench: 1024 bytes, addresses wrap.
// Accepted requests are answered 3 cycles later, in acceptance order.
// Busy is raised at random about one cycle in four; outputs change on the falling edge.
`timescale 1ns/1ps
`default_nettype none

module mem_model import dma_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire mem_req_t mem_req,
    input  wire logic     mem_req_valid,
    output mem_rsp_t      mem_rsp,
    output logic          mem_busy
);

    localparam int          MEM_BYTES = 1024;
    localparam int          LATENCY   = 3;
    localparam logic [31:0] BUSY_SEED = 32'h458c342d;

    logic [7:0] mem [0:MEM_BYTES-1];
    mem_req_t   inflight_req [$];
    int         inflight_due [$];
    int         cyc_count;

    task automatic respond(input mem_req_t r);
        int base;
        int k;
        base          = int'(r.addr) % MEM_BYTES;
        mem_rsp.seq   = r.seq;
        mem_rsp.mask  = r.mask;
        mem_rsp.rdone = !r.wr;
        mem_rsp.wdone = r.wr;
        for (k = 0; k < 4; k++)
        begin
            if (!r.wr)
                mem_rsp.data[8*k +: 8] = mem[base + k];
            else if (r.mask[k])
                mem[base + k] = r.wdata[8*k +: 8];
        end
    endtask

    initial
    begin
        void'($urandom(BUSY_SEED));
        cyc_count = 0;
        mem_busy  = 1'b0;
        mem_rsp   = '0;
        forever
        begin
            @(negedge clk);
            cyc_count = cyc_count + 1;
            mem_rsp   = '0;
            if (rst)
            begin
                inflight_req.delete();
                inflight_due.delete();
                mem_busy = 1'b0;
            end
            else
            begin
                if (inflight_due.size() > 0 && inflight_due[0] == cyc_count)
                begin
                    respond(inflight_req.pop_front());
                    void'(inflight_due.pop_front());
                end
                mem_busy = ($urandom % 4) == 0;
                // Request is stable until the next rising edge, where it is taken
                if (mem_req_valid && !mem_busy)
                begin
                    inflight_req.push_back(mem_req);
                    inflight_due.push_back(cyc_count + LATENCY);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_dma.sv
// Table-driven testbench for the four-channel DMA.
// A byte-level reference model predicts memory and registers for each row.
// Memory holds 1024 bytes, so every row stays below address 0x400.
`timescale 1ns/1ps
`default_nettype none

module tb_dma import dma_pkg::*;
();

    localparam int NUM_ROWS  = 6;
    localparam int MEM_BYTES = 1024;
    localparam int START_CYC = 10;
    localparam int DONE_CYC  = 4000;
    localparam int STALL_CYC = 30;

    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [1:0]        size;
        logic              src_inc;
        logic              dst_inc;
        logic              null_term;
        logic [ADDR_W-1:0] cnt;
        logic [3:0]        src_line;
        logic [3:0]        dst_line;
        logic              held;
        logic [9:0]        zero_at;
    } case_t;

    logic                clk;
    logic                rst;
    logic                reg_wr;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0]   reg_wdata;
    logic [DATA_W-1:0]   reg_rdata;
    mem_req_t            mem_req;
    logic                mem_req_valid;
    logic                mem_busy;
    mem_rsp_t            mem_rsp;
    logic [NUM_REQ-1:0]  req;
    logic [NUM_CHAN-1:0] done;

    case_t      rows [0:NUM_ROWS-1];
    logic [7:0] exp_mem [0:MEM_BYTES-1];
    int         checks;
    int         errors;
    int         timeouts;
    bit         abort;

    dma_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_busy      (mem_busy),
        .mem_rsp       (mem_rsp),
        .req           (req),
        .done          (done)
    );

    mem_model mem0 (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_rsp       (mem_rsp),
        .mem_busy      (mem_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [CHAN_W-1:0] ch, input logic [BLK_W-1:0] off,
                             input logic [DATA_W-1:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = {ch, off};
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input logic [CHAN_W-1:0] ch, input logic [BLK_W-1:0] off,
                            output logic [DATA_W-1:0] data);
        @(negedge clk);
        reg_addr = {ch, off};
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic wait_done(input int ch, input logic level, input int limit, output bit ok);
        int n;
        n = 0;
        while (done[ch] !== level && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        ok = (done[ch] === level);
        if (!ok)
        begin
            timeouts++;
            $display("Timeout: done[%0d] did not reach %0b within %0d cycles", ch, level, limit);
        end
    endtask

    function automatic logic [7:0] fill_byte(input int a, input int row);
        return 8'(a * 37 + (a >> 8) * 5 + row * 29 + 1);
    endfunction

    task automatic preload(input int idx, input case_t r);
        int a;
        for (a = 0; a < MEM_BYTES; a++)
        begin
            exp_mem[a]  = fill_byte(a, idx);
            mem0.mem[a] = exp_mem[a];
        end
        // Planted zero unit for null termination
        if (r.null_term)
        begin
            exp_mem[int'(r.src) + int'(r.zero_at)]  = 8'h00;
            mem0.mem[int'(r.src) + int'(r.zero_at)] = 8'h00;
        end
    endtask

    task automatic compare_mem(input string tag);
        int a;
        for (a = 0; a < MEM_BYTES; a++)
            check_value($sformatf("%s mem[%0d]", tag, a), mem0.mem[a], exp_mem[a]);
    endtask

    // Unit-by-unit copy on exp_mem with the address and count rules
    task automatic model_transfer(input case_t r, output logic [ADDR_W-1:0] s,
                                  output logic [ADDR_W-1:0] d);
        logic [ADDR_W-1:0] c;
        logic [ADDR_W-1:0] align;
        logic [DATA_W-1:0] unit;
        int                nb;
        int                k;
        nb    = (r.size == SIZE_8) ? 1 : (r.size == SIZE_16) ? 2 : 4;
        align = ~ADDR_W'(nb - 1);
        s     = r.src;
        d     = r.dst;
        c     = r.cnt;
        while (c != '0)
        begin
            unit = '0;
            for (k = 0; k < nb; k++)
                unit[8*k +: 8] = exp_mem[int'(s & align) + k];
            for (k = 0; k < nb; k++)
                exp_mem[int'(d & align) + k] = unit[8*k +: 8];
            if (r.src_inc)
                s = (s + ADDR_W'(nb)) & align;
            if (r.dst_inc)
                d = (d + ADDR_W'(nb)) & align;
            if (r.null_term && unit == '0)
                c = '0;
            else
                c = (c - ADDR_W'(nb)) & align;
        end
    endtask

    task automatic run_row(input int idx, input case_t r);
        logic [CTRL_W-1:0] ctrl;
        logic [ADDR_W-1:0] exp_src;
        logic [ADDR_W-1:0] exp_dst;
        logic [DATA_W-1:0] rdata;
        string             tag;
        bit                ok;
        int                n;
        ctrl                                 = '0;
        ctrl[CTRL_SRC_REQ_LSB +: 4]          = r.src_line;
        ctrl[CTRL_DST_REQ_LSB +: 4]          = r.dst_line;
        ctrl[CTRL_SRC_INC]                   = r.src_inc;
        ctrl[CTRL_DST_INC]                   = r.dst_inc;
        ctrl[CTRL_SIZE_LSB +: 2]             = r.size;
        ctrl[CTRL_NULL_TERM]                 = r.null_term;
        tag = $sformatf("row %0d ch %0d", idx, r.chan);
        preload(idx, r);

        // Upper bits carry junk that read-back must drop
        write_reg(r.chan, REG_SRC, {8'hc3, r.src});
        write_reg(r.chan, REG_DST, {8'h5a, r.dst});
        write_reg(r.chan, REG_CTRL, {19'h2a5a5, ctrl});
        read_reg(r.chan, REG_SRC, rdata);
        check_value($sformatf("%s src", tag), rdata, {8'h00, r.src});
        read_reg(r.chan, REG_DST, rdata);
        check_value($sformatf("%s dst", tag), rdata, {8'h00, r.dst});
        read_reg(r.chan, REG_CTRL, rdata);
        check_value($sformatf("%s ctrl", tag), rdata, {1'b1, 18'b0, ctrl});
        check_value($sformatf("%s done before start", tag), done[r.chan], 1'b1);

        req[r.src_line] = r.held;
        req[r.dst_line] = 1'b1;
        write_reg(r.chan, REG_CNT, {8'h3c, r.cnt});
        wait_done(r.chan, 1'b0, START_CYC, ok);

        if (ok && !r.held)
        begin
            for (n = 0; n < STALL_CYC; n++)
            begin
                @(negedge clk);
                check_value($sformatf("%s done while stalled", tag), done[r.chan], 1'b0);
            end
            compare_mem($sformatf("%s stalled", tag));
            read_reg(r.chan, REG_CTRL, rdata);
            check_value($sformatf("%s stalled ctrl bit 31", tag), rdata[CTRL_DONE_BIT], 1'b0);
            req[r.src_line] = 1'b1;
        end
        if (ok)
            wait_done(r.chan, 1'b1, DONE_CYC, ok);

        if (!ok)
        begin
            abort = 1'b1;
        end
        else
        begin
            model_transfer(r, exp_src, exp_dst);
            compare_mem(tag);
            read_reg(r.chan, REG_SRC, rdata);
            check_value($sformatf("%s final src", tag), rdata, {8'h00, exp_src});
            read_reg(r.chan, REG_DST, rdata);
            check_value($sformatf("%s final dst", tag), rdata, {8'h00, exp_dst});
            read_reg(r.chan, REG_CNT, rdata);
            check_value($sformatf("%s final cnt", tag), rdata, 32'h0);
            read_reg(r.chan, REG_CTRL, rdata);
            check_value($sformatf("%s final ctrl", tag), rdata, {1'b1, 18'b0, ctrl});
            check_value($sformatf("%s final done", tag), done[r.chan], 1'b1);
        end
        req = '0;
    endtask

    initial
    begin
        int                idx;
        int                ch;
        logic [DATA_W-1:0] rdata;
        rst       = 1'b1;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        req       = '0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        abort     = 1'b0;

        // chan, src, dst, size, src_inc, dst_inc, null, cnt, src line, dst line, held, zero at
        rows[0] = '{2'd0, 24'h040, 24'h100, SIZE_32, 1'b1, 1'b1, 1'b0, 24'd32, 4'd1, 4'd2,
                    1'b1, 10'd0};
        rows[1] = '{2'd1, 24'h081, 24'h142, SIZE_8, 1'b1, 1'b1, 1'b0, 24'd11, 4'd3, 4'd4,
                    1'b1, 10'd0};
        rows[2] = '{2'd2, 24'h0c6, 24'h180, SIZE_16, 1'b0, 1'b1, 1'b0, 24'd12, 4'd5, 4'd6,
                    1'b1, 10'd0};
        rows[3] = '{2'd3, 24'h200, 24'h280, SIZE_8, 1'b1, 1'b1, 1'b1, 24'd16, 4'd7, 4'd8,
                    1'b1, 10'd5};
        rows[4] = '{2'd1, 24'h300, 24'h340, SIZE_32, 1'b1, 1'b1, 1'b0, 24'd16, 4'd9, 4'd10,
                    1'b0, 10'd0};
        rows[5] = '{2'd0, 24'h3a0, 24'h3f0, 2'd3, 1'b1, 1'b0, 1'b0, 24'd8, 4'd11, 4'd12,
                    1'b1, 10'd0};

        repeat (8) @(negedge clk);
        check_value("done in reset", done, 4'h0);
        rst = 1'b0;
        @(negedge clk);
        check_value("done after reset", done, 4'hf);

        for (idx = 0; idx < NUM_ROWS && !abort; idx++)
            run_row(idx, rows[idx]);

        for (ch = 0; ch < NUM_CHAN && !abort; ch++)
        begin
            read_reg(CHAN_W'(ch), REG_CTRL, rdata);
            check_value($sformatf("ch %0d idle ctrl bit 31", ch), rdata[CTRL_DONE_BIT], 1'b1);
            check_value($sformatf("ch %0d idle done", ch), done[ch], 1'b1);
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && !abort)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/dma_pkg.sv
logic/dma_regs.sv
logic/dma_rsp_track.sv
logic/dma_engine.sv
logic/dma_top.sv
test/mem_model.sv
test/tb_dma.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator.
# The log is searched for the pass line to decide the result.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_dma \
    --Mdir "$BUILD_DIR" -o tb_dma
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_dma" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
exit 1
